/* verilog/mem_block_defs.svh */
// Memory stage sizes
`ifndef MEM_BLOCK_DEFS_SVH
`define MEM_BLOCK_DEFS_SVH

// Data and address width
`define MB_XLEN 32

// Reorder-buffer tag and physical destination widths
`define MB_ROB_W 6
`define MB_PDEST_W 6

// Local data memory depth in 32-bit words
`define MB_DMEM_WORDS 64

// Cycles from an accepted request to its response
`define MB_DMEM_LAT 3

`endif

/* verilog/mem_block_pkg.sv */
// Memory stage shared types
`include "mem_block_defs.svh"

package mem_block_pkg;

  // ========================================
  // Encodings
  // ========================================
  typedef enum logic [0:0] {
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  // Access size, unsigned variants zero-extend on load
  typedef enum logic [2:0] {
    ALIGN_B,
    ALIGN_H,
    ALIGN_W,
    ALIGN_BU,
    ALIGN_HU
  } align_e;

  typedef enum logic [1:0] {
    ATOM_IDLE,
    ATOM_BOOT,
    ATOM_WAIT
  } atomic_state_e;

  // ========================================
  // Stage records
  // ========================================
  typedef struct packed {
    logic                   valid;
    mem_op_e                mem_op;
    align_e                 align_op;
    logic                   atomic;
    logic [`MB_XLEN-1:0]    src0;     // base
    logic [`MB_XLEN-1:0]    imm;
    logic [`MB_XLEN-1:0]    src1;     // store data
    logic [`MB_PDEST_W-1:0] pdest;
    logic                   pdest_valid;
    logic [`MB_ROB_W-1:0]   rob_idx;
  } mem_exe_t;

  typedef struct packed {
    logic                   valid;
    logic [`MB_XLEN-1:0]    vaddr;
    logic [`MB_XLEN-1:0]    wdata;
    mem_op_e                mem_op;
    align_e                 align_op;
    logic                   atomic;
    logic [`MB_PDEST_W-1:0] pdest;
    logic                   pdest_valid;
    logic [`MB_ROB_W-1:0]   rob_idx;
  } dmem_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`MB_XLEN-1:0]    rdata;    // lane-shifted, not yet extended
    mem_op_e                mem_op;
    align_e                 align_op;
    logic                   atomic;
    logic                   llbit;
    logic                   excp;
    logic [`MB_XLEN-1:0]    vaddr;
    logic [`MB_PDEST_W-1:0] pdest;
    logic                   pdest_valid;
    logic [`MB_ROB_W-1:0]   rob_idx;
  } dmem_rsp_t;

  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`MB_XLEN-1:0]    wdata;
    logic [`MB_PDEST_W-1:0] pdest;
    logic [`MB_ROB_W-1:0]   rob_idx;
    logic                   excp;
    logic [`MB_XLEN-1:0]    vaddr;
    mem_op_e                mem_op;
    logic                   atomic;
  } mem_wb_t;

endpackage : mem_block_pkg

/* verilog/mem_issue_stage.sv */
// Memory issue stage
`timescale 1ns/1ps

module mem_issue_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  mem_block_pkg::mem_exe_t  exe_i,
  output logic                     exe_ready_o,
  output mem_block_pkg::dmem_req_t dmem_req_o,
  input  logic                     req_ready_i,
  input  logic                     wb_fire_i
);

  import mem_block_pkg::*;

  atomic_state_e atom_state_q;
  mem_exe_t      s1_q;
  logic          req_accept;
  logic          s1_load;
  logic          atomic_accept;

  // ========================================
  // Handshakes
  // ========================================
  assign req_accept = dmem_req_o.valid & req_ready_i;

  // Register is free when empty or when memory takes its request
  assign s1_load = ~s1_q.valid | req_accept;

  // No new work while an atomic is anywhere in the pipe
  assign exe_ready_o = (atom_state_q == ATOM_IDLE) & s1_load;

  assign atomic_accept = exe_ready_o & exe_i.valid & exe_i.atomic;

  // ========================================
  // Atomic access FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      atom_state_q <= ATOM_IDLE;
    end else if (flush_i) begin
      atom_state_q <= ATOM_IDLE;
    end else begin
      case (atom_state_q)
        ATOM_IDLE: begin
          if (atomic_accept) begin
            atom_state_q <= ATOM_BOOT;
          end
        end
        ATOM_BOOT: begin
          if (req_accept) begin
            atom_state_q <= ATOM_WAIT;
          end
        end
        ATOM_WAIT: begin
          // Released once the atomic record leaves the stage
          if (wb_fire_i) begin
            atom_state_q <= ATOM_IDLE;
          end
        end
        default: begin
          atom_state_q <= ATOM_IDLE;
        end
      endcase
    end
  end

  // ========================================
  // Stage-1 register
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_q <= '0;
    end else if (flush_i) begin
      s1_q <= '0;
    end else if (exe_ready_o) begin
      s1_q <= exe_i;
    end else if (req_accept) begin
      // Atomic handed to memory, input stays closed
      s1_q.valid <= 1'b0;
    end
  end

  // Address generation and request steering
  always_comb begin
    dmem_req_o.valid       = s1_q.valid;
    dmem_req_o.vaddr       = s1_q.src0 + s1_q.imm;
    dmem_req_o.wdata       = s1_q.src1;
    dmem_req_o.mem_op      = s1_q.mem_op;
    dmem_req_o.align_op    = s1_q.align_op;
    dmem_req_o.atomic      = s1_q.atomic;
    dmem_req_o.pdest       = s1_q.pdest;
    dmem_req_o.pdest_valid = s1_q.pdest_valid;
    dmem_req_o.rob_idx     = s1_q.rob_idx;
  end

  // ========================================
  // Checks
  // ========================================
  // A pending request must not change until memory takes it
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    dmem_req_o.valid && !req_ready_i |=> $stable(dmem_req_o)
  ) else $error("dmem request changed while stalled");

endmodule : mem_issue_stage

/* verilog/dmem_unit.sv */
// Multi-cycle data memory
`timescale 1ns/1ps
`include "mem_block_defs.svh"

module dmem_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  mem_block_pkg::dmem_req_t req_i,
  output logic                     req_ready_o,
  output mem_block_pkg::dmem_rsp_t rsp_o,
  input  logic                     rsp_ready_i
);

  import mem_block_pkg::*;

  localparam int IDX_W = $clog2(`MB_DMEM_WORDS);
  localparam int CNT_W = $clog2(`MB_DMEM_LAT + 1);

  logic [`MB_XLEN-1:0] mem_q [`MB_DMEM_WORDS];

  dmem_req_t           req_q;
  logic                busy_q;
  logic                rsp_valid_q;
  logic [CNT_W-1:0]    cnt_q;
  logic                llbit_q;
  logic [`MB_XLEN-1:0] rdata_q;
  logic                llold_q;

  logic                req_accept;
  logic                rsp_fire;
  logic                op_fire;
  logic                misalign_in;
  logic                misalign_q;
  logic [IDX_W-1:0]    word_idx;
  logic [1:0]          byte_off;
  logic [3:0]          wmask;
  logic [`MB_XLEN-1:0] wdata_sh;
  logic                do_write;

  function automatic logic is_misaligned(align_e align, logic [1:0] addr_lo);
    logic bad;
    case (align)
      ALIGN_H, ALIGN_HU: bad = addr_lo[0];
      ALIGN_W:           bad = |addr_lo;
      default:           bad = 1'b0;
    endcase
    return bad;
  endfunction

  // ========================================
  // Control
  // ========================================
  assign req_ready_o = ~busy_q;
  assign req_accept  = req_i.valid & req_ready_o;
  assign rsp_fire    = rsp_valid_q & rsp_ready_i;
  assign op_fire     = busy_q & ~rsp_valid_q & (cnt_q == '0) & ~flush_i;

  assign misalign_in = is_misaligned(req_i.align_op, req_i.vaddr[1:0]);
  assign misalign_q  = is_misaligned(req_q.align_op, req_q.vaddr[1:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      cnt_q       <= '0;
      llbit_q     <= 1'b0;
    end else if (flush_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      cnt_q       <= '0;
    end else if (req_accept) begin
      busy_q <= 1'b1;
      // Misaligned accesses answer on the next cycle
      cnt_q  <= misalign_in ? '0 : CNT_W'(`MB_DMEM_LAT - 1);
    end else if (rsp_fire) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else if (op_fire) begin
      rsp_valid_q <= 1'b1;
      if (req_q.atomic && !misalign_q) begin
        // LL sets the link, SC always consumes it
        llbit_q <= (req_q.mem_op == MEM_LOAD);
      end
    end else if (busy_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // ========================================
  // Array access
  // ========================================
  assign word_idx = req_q.vaddr[IDX_W+1:2];
  assign byte_off = req_q.vaddr[1:0];
  assign wdata_sh = req_q.wdata << {byte_off, 3'b000};

  always_comb begin
    case (req_q.align_op)
      ALIGN_B, ALIGN_BU: wmask = 4'b0001 << byte_off;
      ALIGN_H, ALIGN_HU: wmask = 4'b0011 << byte_off;
      default:           wmask = 4'b1111;
    endcase
  end

  // SC only writes while the link holds
  assign do_write = op_fire & (req_q.mem_op == MEM_STORE) & ~misalign_q &
                    (~req_q.atomic | llbit_q);

  always_ff @(posedge clk) begin
    if (req_accept) begin
      req_q <= req_i;
    end
    if (op_fire) begin
      rdata_q <= misalign_q ? '0 : (mem_q[word_idx] >> {byte_off, 3'b000});
      llold_q <= misalign_q ? 1'b0 : llbit_q;
    end
    if (do_write) begin
      for (int i = 0; i < 4; i++) begin
        if (wmask[i]) begin
          mem_q[word_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    rsp_o.valid       = rsp_valid_q;
    rsp_o.rdata       = rdata_q;
    rsp_o.mem_op      = req_q.mem_op;
    rsp_o.align_op    = req_q.align_op;
    rsp_o.atomic      = req_q.atomic;
    rsp_o.llbit       = llold_q;
    rsp_o.excp        = misalign_q;
    rsp_o.vaddr       = req_q.vaddr;
    rsp_o.pdest       = req_q.pdest;
    rsp_o.pdest_valid = req_q.pdest_valid;
    rsp_o.rob_idx     = req_q.rob_idx;
  end

  // ========================================
  // Checks
  // ========================================
  // A response rises a fixed time after the request that caused it
  a_rsp_after_req: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    $rose(rsp_o.valid) |->
      ($past(req_accept, `MB_DMEM_LAT + 1) && !$past(misalign_in, `MB_DMEM_LAT + 1)) ||
      ($past(req_accept, 2) && $past(misalign_in, 2))
  ) else $error("response without an accepted request");

  a_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_accept |-> (req_i.vaddr[`MB_XLEN-1:2] < `MB_DMEM_WORDS)
  ) else $error("address outside data memory");

endmodule : dmem_unit

/* verilog/mem_writeback.sv */
// Memory write-back stage
`timescale 1ns/1ps
`include "mem_block_defs.svh"

module mem_writeback (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  mem_block_pkg::dmem_rsp_t rsp_i,
  output logic                     rsp_ready_o,
  output mem_block_pkg::mem_wb_t   wb_o,
  input  logic                     wb_ready_i,
  output logic                     atomic_done_o
);

  import mem_block_pkg::*;

  mem_wb_t             wb_q;
  mem_wb_t             wb_d;
  logic [`MB_XLEN-1:0] load_data;
  logic                rsp_fire;

  // Sign or zero extension of the lane-shifted read
  always_comb begin
    case (rsp_i.align_op)
      ALIGN_B:  load_data = {{(`MB_XLEN-8){rsp_i.rdata[7]}}, rsp_i.rdata[7:0]};
      ALIGN_BU: load_data = {{(`MB_XLEN-8){1'b0}}, rsp_i.rdata[7:0]};
      ALIGN_H:  load_data = {{(`MB_XLEN-16){rsp_i.rdata[15]}}, rsp_i.rdata[15:0]};
      ALIGN_HU: load_data = {{(`MB_XLEN-16){1'b0}}, rsp_i.rdata[15:0]};
      default:  load_data = rsp_i.rdata;
    endcase
  end

  // Record assembly
  always_comb begin
    wb_d.valid   = rsp_i.valid;
    // Loads and SC write a register, faults never do
    wb_d.we      = rsp_i.pdest_valid & ~rsp_i.excp &
                   ((rsp_i.mem_op == MEM_LOAD) | rsp_i.atomic);
    wb_d.wdata   = (rsp_i.mem_op == MEM_LOAD) ? load_data :
                   {{(`MB_XLEN-1){1'b0}}, rsp_i.llbit & rsp_i.atomic};
    wb_d.pdest   = rsp_i.pdest;
    wb_d.rob_idx = rsp_i.rob_idx;
    wb_d.excp    = rsp_i.excp;
    wb_d.vaddr   = rsp_i.vaddr;
    wb_d.mem_op  = rsp_i.mem_op;
    wb_d.atomic  = rsp_i.atomic;
  end

  // ========================================
  // Holding register
  // ========================================
  assign rsp_ready_o = ~wb_q.valid | wb_ready_i;
  assign rsp_fire    = rsp_i.valid & rsp_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (flush_i) begin
      wb_q <= '0;
    end else if (rsp_fire) begin
      wb_q <= wb_d;
    end else if (wb_ready_i) begin
      wb_q.valid <= 1'b0;
    end
  end

  assign wb_o          = wb_q;
  assign atomic_done_o = wb_q.valid & wb_q.atomic & wb_ready_i;

  a_wb_stable: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    wb_o.valid && !wb_ready_i |=> $stable(wb_o)
  ) else $error("write-back record changed under back-pressure");

endmodule : mem_writeback

/* verilog/mem_block.sv */
// Memory stage top level
`timescale 1ns/1ps

module mem_block (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  mem_block_pkg::mem_exe_t exe_i,
  output logic                    exe_ready_o,
  output mem_block_pkg::mem_wb_t  wb_o,
  input  logic                    wb_ready_i
);

  import mem_block_pkg::*;

  dmem_req_t dmem_req;
  dmem_rsp_t dmem_rsp;
  logic      req_ready;
  logic      rsp_ready;
  logic      atomic_done;

  // Issue, memory and write-back in series
  mem_issue_stage i_mem_issue_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .exe_i       (exe_i),
    .exe_ready_o (exe_ready_o),
    .dmem_req_o  (dmem_req),
    .req_ready_i (req_ready),
    .wb_fire_i   (atomic_done)
  );

  dmem_unit i_dmem_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .req_i       (dmem_req),
    .req_ready_o (req_ready),
    .rsp_o       (dmem_rsp),
    .rsp_ready_i (rsp_ready)
  );

  mem_writeback i_mem_writeback (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .rsp_i         (dmem_rsp),
    .rsp_ready_o   (rsp_ready),
    .wb_o          (wb_o),
    .wb_ready_i    (wb_ready_i),
    .atomic_done_o (atomic_done)
  );

endmodule : mem_block

/* dv/mem_block_tb.sv */
// Memory stage testbench
`timescale 1ns/1ps
`include "mem_block_defs.svh"

module mem_block_tb;

  import mem_block_pkg::*;

  localparam string GOLDEN_FILE = "dv/mem_block_golden.txt";

  // Expected write-back of one operation
  typedef struct packed {
    logic                   we;
    logic [`MB_XLEN-1:0]    wdata;
    logic                   excp;
    logic [`MB_PDEST_W-1:0] pdest;
    logic [`MB_ROB_W-1:0]   rob_idx;
    logic [`MB_XLEN-1:0]    vaddr;
    mem_op_e                mem_op;
    logic                   atomic;
  } wb_expect_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       flush_i;
  mem_exe_t   exe_i;
  logic       exe_ready_o;
  mem_wb_t    wb_o;
  logic       wb_ready_i = 1'b0;

  mem_exe_t   ops[$];
  wb_expect_t expects[$];
  wb_expect_t pending_q[$];
  wb_expect_t cur_expect;
  logic       atomic_open = 1'b0;
  int         op_count = 0;
  int         checked_count = 0;
  int         cycle_count = 0;
  int         cycle_limit = 200;

  mem_block i_mem_block (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .exe_i       (exe_i),
    .exe_ready_o (exe_ready_o),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i)
  );

  always #5 clk = ~clk;

  // ========================================
  // Helpers
  // ========================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] want);
    abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, field, got, want));
  endtask

  task automatic check_record(input wb_expect_t exp_rec);
    assert (wb_o.rob_idx == exp_rec.rob_idx)
      else report_mismatch("wb_o.rob_idx", 32'(wb_o.rob_idx), 32'(exp_rec.rob_idx));
    assert (wb_o.pdest == exp_rec.pdest)
      else report_mismatch("wb_o.pdest", 32'(wb_o.pdest), 32'(exp_rec.pdest));
    assert (wb_o.excp == exp_rec.excp)
      else report_mismatch("wb_o.excp", 32'(wb_o.excp), 32'(exp_rec.excp));
    assert (wb_o.we == exp_rec.we)
      else report_mismatch("wb_o.we", 32'(wb_o.we), 32'(exp_rec.we));
    assert (wb_o.vaddr == exp_rec.vaddr)
      else report_mismatch("wb_o.vaddr", wb_o.vaddr, exp_rec.vaddr);
    assert (wb_o.mem_op == exp_rec.mem_op)
      else report_mismatch("wb_o.mem_op", 32'(wb_o.mem_op), 32'(exp_rec.mem_op));
    assert (wb_o.atomic == exp_rec.atomic)
      else report_mismatch("wb_o.atomic", 32'(wb_o.atomic), 32'(exp_rec.atomic));
    // Data only matters when a register is written
    if (exp_rec.we) begin
      assert (wb_o.wdata == exp_rec.wdata)
        else report_mismatch("wb_o.wdata", wb_o.wdata, exp_rec.wdata);
    end
  endtask

  task automatic load_golden();
    int               fd;
    int               n_chars;
    int               n_fields;
    logic [8*128-1:0] line_buf;
    logic [31:0]      col [12];
    mem_exe_t         op;
    wb_expect_t       exp_rec;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      abort_run("Cannot open the golden file");
    end
    line_buf = '0;
    n_chars = $fgets(line_buf, fd);
    while (n_chars != 0) begin
      n_fields = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h",
                         col[0], col[1], col[2], col[3], col[4], col[5],
                         col[6], col[7], col[8], col[9], col[10], col[11]);
      // Comment and blank lines give no fields
      if (n_fields == 12) begin
        op             = '0;
        op.valid       = 1'b1;
        op.mem_op      = mem_op_e'(col[0][0]);
        op.align_op    = align_e'(col[1][2:0]);
        op.atomic      = col[2][0];
        op.src0        = col[3];
        op.imm         = col[4];
        op.src1        = col[5];
        op.pdest       = col[6][`MB_PDEST_W-1:0];
        op.pdest_valid = col[7][0];
        op.rob_idx     = col[8][`MB_ROB_W-1:0];
        exp_rec.we      = col[9][0];
        exp_rec.wdata   = col[10];
        exp_rec.excp    = col[11][0];
        exp_rec.pdest   = op.pdest;
        exp_rec.rob_idx = op.rob_idx;
        exp_rec.vaddr   = op.src0 + op.imm;
        exp_rec.mem_op  = op.mem_op;
        exp_rec.atomic  = op.atomic;
        ops.push_back(op);
        expects.push_back(exp_rec);
      end
      line_buf = '0;
      n_chars = $fgets(line_buf, fd);
    end
    $fclose(fd);
  endtask

  // ========================================
  // Stimulus
  // ========================================
  // Output back-pressure on about a quarter of the cycles
  always @(negedge clk) begin
    wb_ready_i = (($urandom % 4) != 0);
  end

  initial begin
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    exe_i      = '0;
    cur_expect = '0;
    void'($urandom(76299));
    load_golden();
    op_count = ops.size();
    if (op_count == 0) begin
      abort_run("The golden file holds no operations");
    end
    cycle_limit = op_count * 40 + 200;

    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < op_count; i++) begin
      @(negedge clk);
      exe_i      = ops[i];
      cur_expect = expects[i];
      // Hold the operation until the issue stage takes it
      do begin
        @(posedge clk);
      end while (!exe_ready_o);
    end
    @(negedge clk);
    exe_i = '0;

    wait (checked_count == op_count);
    repeat (2) @(negedge clk);
    if (pending_q.size() == 0 && checked_count == op_count) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("Write-back records are missing at the end of the run");
    end
  end

  // ========================================
  // Monitor and scoreboard
  // ========================================
  always @(posedge clk) begin
    wb_expect_t exp_rec;
    if (rst_n) begin
      if (atomic_open) begin
        assert (!exe_ready_o)
          else abort_run("exe_ready_o went high before the atomic write-back transferred");
      end
      if (exe_i.valid && exe_ready_o) begin
        pending_q.push_back(cur_expect);
        if (exe_i.atomic) begin
          atomic_open = 1'b1;
        end
      end
      if (wb_o.valid && wb_ready_i) begin
        if (pending_q.size() == 0) begin
          abort_run("A write-back record arrived with no operation outstanding");
        end else begin
          exp_rec = pending_q.pop_front();
          check_record(exp_rec);
          checked_count++;
          if (exp_rec.atomic) begin
            atomic_open = 1'b0;
          end
        end
      end
    end
  end

  // Run length guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles with write-backs still missing",
                          cycle_count));
    end
  end

endmodule : mem_block_tb

/* mem_block.f */
+incdir+verilog
verilog/mem_block_pkg.sv
verilog/mem_issue_stage.sv
verilog/dmem_unit.sv
verilog/mem_writeback.sv
verilog/mem_block.sv
dv/mem_block_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_block_tb
FILELIST  ?= mem_block.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/mem_block_golden.txt */
# op align atomic src0 imm src1 pdest pdest_valid rob_idx | exp_we exp_wdata exp_excp
# op 0=load 1=store, align 0=B 1=H 2=W 3=BU 4=HU, all fields hex
1 2 0 00000010 00000000 8899aabb 3f 1 00 0 00000000 0
1 2 0 00000010 00000004 00000000 3e 1 01 0 00000000 0
1 0 0 00000014 00000000 123456f1 3d 1 02 0 00000000 0
1 0 0 00000014 00000002 abcdef7e 3c 1 03 0 00000000 0
1 2 0 00000018 00000000 11223344 3b 1 04 0 00000000 0
1 1 0 00000018 00000002 0000c3d2 3a 1 05 0 00000000 0
0 2 0 00000010 00000000 00000000 39 1 06 1 8899aabb 0
0 0 0 00000010 00000000 00000000 38 1 07 1 ffffffbb 0
0 3 0 00000010 00000001 00000000 37 1 08 1 000000aa 0
0 1 0 00000010 00000002 00000000 36 1 09 1 ffff8899 0
0 4 0 00000010 00000000 00000000 35 1 0a 1 0000aabb 0
0 2 0 00000014 00000000 00000000 34 1 0b 1 007e00f1 0
0 0 0 00000014 00000002 00000000 33 1 0c 1 0000007e 0
0 0 0 00000014 00000000 00000000 32 1 0d 1 fffffff1 0
0 1 0 00000018 00000002 00000000 31 1 0e 1 ffffc3d2 0
0 4 0 00000018 00000000 00000000 30 1 0f 1 00003344 0
0 3 0 00000018 00000003 00000000 2f 1 10 1 000000c3 0
1 1 0 00000014 00000001 0000dead 2e 1 11 0 00000000 1
1 2 0 00000010 00000002 ffffffff 2d 1 12 0 00000000 1
0 2 0 00000010 00000001 00000000 2c 1 13 0 00000000 1
0 1 0 00000010 00000003 00000000 2b 1 14 0 00000000 1
0 2 0 00000020 fffffff0 00000000 2a 1 15 1 8899aabb 0
0 2 0 00000014 00000000 00000000 29 1 16 1 007e00f1 0
0 2 1 00000018 00000000 00000000 28 1 17 1 c3d23344 0
1 2 1 00000018 00000000 5a5a5a5a 27 1 18 1 00000001 0
1 2 1 00000018 00000000 01010101 26 1 19 1 00000000 0
0 2 0 00000018 00000000 00000000 25 1 1a 1 5a5a5a5a 0
0 2 1 00000010 00000000 00000000 24 1 1b 1 8899aabb 0
1 2 1 00000010 00000000 13579bdf 23 0 1c 0 00000000 0
0 2 0 00000010 00000000 00000000 22 1 1d 1 13579bdf 0
